// File: logic/uart_consts.svh
// ################################################
// UART constants: FIFO sizing, register word map,
// and the baud register value after reset
// ################################################
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// FIFO sizing
`define UART_FIFO_DEPTH 8       // Entries per byte FIFO, any power of two
`define UART_FIFO_AW    3       // log2 of the depth

// Register word addresses
`define UART_ADDR_DATA   2'd0   // TX push on write, RX pop on read
`define UART_ADDR_STATUS 2'd1   // FIFO flags, read only
`define UART_ADDR_BAUD   2'd2   // Bit period in sixteenths

// Status word bit positions
`define UART_ST_TX_EMPTY 0
`define UART_ST_TX_FULL  1
`define UART_ST_RX_EMPTY 2
`define UART_ST_RX_FULL  3

// Bit period after reset
// 868 clocks per bit gives 115200 baud from 100 MHz
`define UART_BAUD_RESET 16'd868

`endif

// File: logic/uartPkg.sv
// ################################################
// UART package: byte, bus word, register address,
// bit period and FIFO pointer types
// ################################################
package uartPkg;

  `include "uart_consts.svh"

  // One serial character
  typedef logic [7:0] byteT;

  // Wishbone data word and register word address
  typedef logic [15:0] wbDataT;
  typedef logic [1:0]  wbAddrT;

  // Clocks per bit, 12 integer bits over 4 fraction bits
  typedef logic [15:0] bitPeriodT;

  // FIFO pointer with one extra wrap bit
  typedef logic [`UART_FIFO_AW:0] fifoPtrT;

endpackage

// File: logic/uartCore.sv
// ################################################
// UART core: 8N1 transmitter and receiver, rxd
// synchronizer, fractional baud divider
// ################################################
`timescale 1ns/1ps

module uartCore import uartPkg::*; (
  input  logic      clk,
  input  logic      arstn,
  output logic      ready,      // Transmitter idle
  input  logic      wr,         // One cycle load strobe
  input  byteT      din,        // Byte to send
  output logic      full,       // Received byte waiting in dout
  input  logic      rd,         // Clears full
  output byteT      dout,       // Last received byte
  input  bitPeriodT bitperiod,  // Clocks per bit, 12.4 fixed point
  input  logic      rxd,        // Asynchronous line input
  output logic      txd         // Serial line output
);

  logic        rxdA, rxdB, rxdI;  // Synchronizer chain
  logic [11:0] baudInt;           // Clocks left to next tick
  logic [3:0]  baudFrac;          // Tick index within a bit
  logic        tick;              // 16 per bit period
  logic [7:0]  txState;           // Bits left in high nibble, ticks in low
  logic [7:0]  rxState;           // Same layout as txState
  byteT        txReg;             // Outgoing shift register
  byteT        rxReg;             // Incoming shift register
  logic        tNext;             // Next level for txd
  logic        rxError;           // Zero stop bit seen, wait for mark
  logic        startBit, txShift, rxSample, rxAtStart, rxAtStop;

  // Three flop synchronizer, idles at mark
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      rxdA <= 1'b1;
      rxdB <= 1'b1;
      rxdI <= 1'b1;
    end else begin
      rxdA <= rxd;
      rxdB <= rxdA;
      rxdI <= rxdB;
    end
  end

  // Fractional divider
  // Each tick lasts int or int+1 clocks, frac of 16 ticks get the extra clock
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      baudInt  <= 12'd0;
      baudFrac <= 4'd0;
      tick     <= 1'b0;
    end else begin
      tick <= 1'b0;
      if (baudInt != 12'd0) begin
        baudInt <= baudInt - 12'd1;
      end else begin
        tick <= 1'b1;
        if (bitperiod[3:0] > baudFrac)
          baudInt <= bitperiod[15:4];          // Stretched tick
        else
          baudInt <= bitperiod[15:4] - 12'd1;
        baudFrac <= baudFrac + 4'd1;           // Wraps every 16 ticks
      end
    end
  end

  assign startBit  = ~rxdI & ~rxError;
  assign txShift   = tick && (txState != 8'd0) && (txState[3:0] == 4'd0);  // Bit boundary
  assign rxSample  = tick && (rxState != 8'd0) && (rxState[3:0] == 4'd0);  // Mid bit
  assign rxAtStart = rxSample && (rxState[7:4] == 4'hA);
  assign rxAtStop  = rxSample && (rxState[7:4] == 4'h1);

  // Transmitter control
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      txState <= 8'd0;
      tNext   <= 1'b1;                   // Line at mark
      txd     <= 1'b1;
      ready   <= 1'b1;
    end else begin
      if (tick) begin
        txd <= tNext;
        if (txState != 8'd0)
          txState <= txState - 8'd1;
        else
          ready <= 1'b1;
      end
      if (txShift)
        tNext <= txReg[0];               // LSB first
      if (wr) begin
        tNext   <= 1'b0;                 // Start bit
        txState <= 8'hAF;                // Start, 8 data, stop
        ready   <= 1'b0;
      end
    end
  end

  // Shift register fills with ones, which form the stop bit
  always_ff @(posedge clk) begin
    if (wr)
      txReg <= din;
    else if (txShift)
      txReg <= {1'b1, txReg[7:1]};
  end

  // Receiver control
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      rxState <= 8'd0;
      rxError <= 1'b0;
      full    <= 1'b0;
    end else begin
      if (rd)
        full <= 1'b0;                    // New byte below wins over rd
      if (tick) begin
        if (rxAtStart && rxdI) begin
          rxState <= 8'd0;               // False start, back to idle
        end else if (rxAtStop) begin
          rxState <= 8'd0;               // Idle early to catch the next start
          if (rxdI)
            full <= 1'b1;
          else
            rxError <= 1'b1;             // Framing error or break
        end else if (rxState != 8'd0) begin
          rxState <= rxState - 8'd1;
        end else begin
          rxError <= rxError & ~rxdI;    // Mark clears the hold off
          if (startBit)
            rxState <= 8'hA8;            // Half bit to the start bit middle
        end
      end
    end
  end

  // Receive payload, dout is overwritten even if unread
  always_ff @(posedge clk) begin
    if (rxSample && !rxAtStart && !rxAtStop)
      rxReg <= {rxdI, rxReg[7:1]};
    if (rxAtStop && rxdI)
      dout <= rxReg;
  end

endmodule

// File: logic/byteFifo.sv
// ################################################
// Byte FIFO, first word fall through, wrap bit
// pointers for full and empty
// ################################################
`timescale 1ns/1ps
`include "uart_consts.svh"

module byteFifo import uartPkg::*; (
  input  logic clk,
  input  logic arstn,
  input  logic push,    // Write wrData unless full
  input  byteT wrData,
  input  logic pop,     // Drop head unless empty
  output byteT rdData,  // Head entry
  output logic full,
  output logic empty
);

  byteT    mem [`UART_FIFO_DEPTH];  // Storage
  fifoPtrT wrPtr;                   // Next free slot
  fifoPtrT rdPtr;                   // Head slot
  logic    doPush, doPop;

  assign doPush = push & ~full;
  assign doPop  = pop & ~empty;

  // Same index with the wrap bits apart means full
  assign empty = (wrPtr == rdPtr);
  assign full  = (wrPtr[`UART_FIFO_AW] != rdPtr[`UART_FIFO_AW]) &&
                 (wrPtr[`UART_FIFO_AW-1:0] == rdPtr[`UART_FIFO_AW-1:0]);

  assign rdData = mem[rdPtr[`UART_FIFO_AW-1:0]];

  // Pointers, push and pop in one cycle both move
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      wrPtr <= '0;
      rdPtr <= '0;
    end else begin
      if (doPush)
        wrPtr <= wrPtr + 1'b1;
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (doPush)
      mem[wrPtr[`UART_FIFO_AW-1:0]] <= wrData;
  end

endmodule

// File: logic/uartRegs.sv
// ################################################
// Wishbone classic slave, register decode, baud
// register, TX and RX pumps between FIFOs and core
// ################################################
`timescale 1ns/1ps
`include "uart_consts.svh"

module uartRegs import uartPkg::*; (
  input  logic      clk,
  input  logic      arstn,
  // Wishbone classic slave
  input  logic      cyc,
  input  logic      stb,
  input  logic      we,
  input  wbAddrT    adr,
  input  wbDataT    datI,
  output wbDataT    datO,
  output logic      ack,
  // TX FIFO
  output logic      txPush,
  output byteT      txData,
  input  logic      txFull,
  input  logic      txEmpty,
  output logic      txPop,
  input  byteT      txHead,
  // RX FIFO
  output logic      rxPush,
  output byteT      rxData,
  input  logic      rxFull,
  input  logic      rxEmpty,
  output logic      rxPop,
  input  byteT      rxHead,
  // Core
  input  logic      coreReady,
  input  logic      coreFull,
  input  byteT      coreDout,
  output logic      coreWr,
  output logic      coreRd,
  output byteT      coreDin,
  output bitPeriodT bitperiod
);

  logic   reqSeen;                  // New request, not yet acked
  logic   dataSel, statusSel, baudSel;
  logic   busWrite, busRead;        // Valid in the ack cycle
  logic   wrLast, rdLast;           // Core strobes of the previous cycle
  wbDataT statusWord, readWord;

  assign reqSeen   = cyc & stb & ~ack;
  assign dataSel   = (adr == `UART_ADDR_DATA);
  assign statusSel = (adr == `UART_ADDR_STATUS);
  assign baudSel   = (adr == `UART_ADDR_BAUD);
  assign busWrite  = ack & we;      // Master holds the request through ack
  assign busRead   = ack & ~we;

  // Single cycle ack, one clock after the request
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn)
      ack <= 1'b0;
    else
      ack <= reqSeen;
  end

  // Data register, dropped write when full, no pop when empty
  assign txPush = busWrite & dataSel & ~txFull;
  assign txData = datI[7:0];
  assign rxPop  = busRead & dataSel & ~rxEmpty;

  // Baud register
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn)
      bitperiod <= `UART_BAUD_RESET;
    else if (busWrite && baudSel)
      bitperiod <= datI;
  end

  always_comb begin
    statusWord = '0;
    statusWord[`UART_ST_TX_EMPTY] = txEmpty;
    statusWord[`UART_ST_TX_FULL]  = txFull;
    statusWord[`UART_ST_RX_EMPTY] = rxEmpty;
    statusWord[`UART_ST_RX_FULL]  = rxFull;
  end

  // Read mux, unmapped address reads zero
  always_comb begin
    readWord = '0;
    if (dataSel)
      readWord = rxEmpty ? '0 : {8'd0, rxHead};
    else if (statusSel)
      readWord = statusWord;
    else if (baudSel)
      readWord = bitperiod;
  end

  assign datO = busRead ? readWord : '0;

  // TX pump, FIFO head to core
  assign txPop   = ~txEmpty & coreReady & ~wrLast;
  assign coreWr  = txPop;
  assign coreDin = txHead;

  // RX pump, core byte to FIFO
  assign rxPush = coreFull & ~rxFull & ~rdLast;
  assign coreRd = rxPush;
  assign rxData = coreDout;

  // Holds off a second strobe while the core flags settle
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      wrLast <= 1'b0;
      rdLast <= 1'b0;
    end else begin
      wrLast <= coreWr;
      rdLast <= coreRd;
    end
  end

endmodule

// File: logic/uartTop.sv
// ################################################
// UART top: register block, TX and RX FIFOs, core
// ################################################
`timescale 1ns/1ps

module uartTop import uartPkg::*; (
  input  logic   clk,
  input  logic   arstn,
  input  logic   cyc,
  input  logic   stb,
  input  logic   we,
  input  wbAddrT adr,
  input  wbDataT datI,
  output wbDataT datO,
  output logic   ack,
  input  logic   rxd,   // Serial in
  output logic   txd    // Serial out
);

  logic      txPush, txPop, txFull, txEmpty;
  byteT      txData, txHead;
  logic      rxPush, rxPop, rxFull, rxEmpty;
  byteT      rxData, rxHead;
  logic      coreReady, coreFull, coreWr, coreRd;
  byteT      coreDin, coreDout;
  bitPeriodT bitperiod;

  uartRegs regs (
    .clk(clk), .arstn(arstn),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .datI(datI), .datO(datO), .ack(ack),
    .txPush(txPush), .txData(txData), .txFull(txFull), .txEmpty(txEmpty),
    .txPop(txPop), .txHead(txHead),
    .rxPush(rxPush), .rxData(rxData), .rxFull(rxFull), .rxEmpty(rxEmpty),
    .rxPop(rxPop), .rxHead(rxHead),
    .coreReady(coreReady), .coreFull(coreFull), .coreDout(coreDout),
    .coreWr(coreWr), .coreRd(coreRd), .coreDin(coreDin),
    .bitperiod(bitperiod)
  );

  // Bus to line
  byteFifo txFifo (
    .clk(clk), .arstn(arstn),
    .push(txPush), .wrData(txData),
    .pop(txPop), .rdData(txHead),
    .full(txFull), .empty(txEmpty)
  );

  // Line to bus
  byteFifo rxFifo (
    .clk(clk), .arstn(arstn),
    .push(rxPush), .wrData(rxData),
    .pop(rxPop), .rdData(rxHead),
    .full(rxFull), .empty(rxEmpty)
  );

  uartCore core (
    .clk(clk), .arstn(arstn),
    .ready(coreReady), .wr(coreWr), .din(coreDin),
    .full(coreFull), .rd(coreRd), .dout(coreDout),
    .bitperiod(bitperiod),
    .rxd(rxd), .txd(txd)
  );

endmodule

// File: test/uartTop_chk.sv
// ################################################
// Bus and status assertions, bound into uartTop
// ################################################
`timescale 1ns/1ps

module uartTop_chk (
  input logic clk,
  input logic arstn,
  input logic cyc,
  input logic stb,
  input logic ack,
  input logic txd,
  input logic txEmpty,   // FIFO flags behind the status word
  input logic txFull,
  input logic rxEmpty,
  input logic rxFull
);

  ackNeedsReq: assert property (@(posedge clk) disable iff (!arstn) ack |-> (cyc && stb))
    else $error("ack high without cyc and stb");

  ackOneCycle: assert property (@(posedge clk) disable iff (!arstn) ack |=> !ack)
    else $error("ack held for two cycles");

  txFlags: assert property (@(posedge clk) disable iff (!arstn) !(txEmpty && txFull))
    else $error("TX status shows empty and full");

  rxFlags: assert property (@(posedge clk) disable iff (!arstn) !(rxEmpty && rxFull))
    else $error("RX status shows empty and full");

  // Line idles at mark out of reset
  txdIdle: assert property (@(posedge clk) $rose(arstn) |-> txd)
    else $error("txd low after reset release");

endmodule

bind uartTop uartTop_chk chk (
  .clk(clk), .arstn(arstn), .cyc(cyc), .stb(stb), .ack(ack), .txd(txd),
  .txEmpty(txEmpty), .txFull(txFull), .rxEmpty(rxEmpty), .rxFull(rxFull)
);

// File: test/tb_uartTop.sv
// ################################################
// Testbench for the UART top with bus tasks, loopback,
// line decoder, reference model and checks
// ################################################
`timescale 1ns/1ps
`include "uart_consts.svh"

module tb_uartTop import uartPkg::*; ();

  localparam int BURST_A         = 8;                          // Back to back burst
  localparam int BURST_B         = 12;                         // Read as each byte lands
  localparam int FRAMES          = 1 + BURST_A + BURST_B;
  localparam int TEST_BIT_CLOCKS = 64;                         // 4 clocks per tick
  localparam int CYCLE_LIMIT     = 2 * FRAMES * 10 * TEST_BIT_CLOCKS + 2000;

  logic   clk, arstn;
  logic   cyc, stb, we, ack;
  wbAddrT adr;
  wbDataT datI, datO;
  wire    lineTx;                   // DUT txd
  wire    lineRx;                   // Looped back into rxd

  byteT   txQ[$];                   // Written but not yet seen on txd
  byteT   rxQ[$];                   // Seen on txd but not yet read back
  int     valueErrors, otherErrors;
  int     bitClocks;                // Programmed bit period in clocks
  int     cycleCount = 0;
  integer seed;

  assign lineRx = lineTx;

  uartTop UUT (
    .clk(clk), .arstn(arstn),
    .cyc(cyc), .stb(stb), .we(we), .adr(adr),
    .datI(datI), .datO(datO), .ack(ack),
    .rxd(lineRx), .txd(lineTx)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;          // 8 ns period
  end

  // Expected status word from model occupancy
  function automatic wbDataT refStatus(input int txOcc, input int rxOcc);
    wbDataT s;
    s = '0;
    s[`UART_ST_TX_EMPTY] = (txOcc == 0);
    s[`UART_ST_TX_FULL]  = (txOcc >= `UART_FIFO_DEPTH);
    s[`UART_ST_RX_EMPTY] = (rxOcc == 0);
    s[`UART_ST_RX_FULL]  = (rxOcc >= `UART_FIFO_DEPTH);
    return s;
  endfunction

  task automatic checkWord(input string name, input wbDataT exp, input wbDataT act);
    if (act !== exp) begin
      $display("Fail %0t: %s expected %h got %h", $time, name, exp, act);
      valueErrors++;
    end
  endtask

  // Classic cycle held until ack
  task automatic writeReg(input wbAddrT a, input wbDataT d);
    @(posedge clk);
    cyc  <= 1'b1;
    stb  <= 1'b1;
    we   <= 1'b1;
    adr  <= a;
    datI <= d;
    @(posedge clk);
    while (ack !== 1'b1) @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic readReg(input wbAddrT a, output wbDataT d);
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= a;
    @(posedge clk);
    while (ack !== 1'b1) @(posedge clk);
    d   = datO;                     // Valid in the ack cycle
    cyc <= 1'b0;
    stb <= 1'b0;
  endtask

  // Polls status until one bit reaches a level within a frame budget
  task automatic waitStatus(input int bitIdx, input logic level, input int frames,
                            output logic ok);
    wbDataT st;
    int     polls;
    int     limit;
    limit = frames * 14 * bitClocks / 3 + 16;   // About 3 clocks per read
    polls = 0;
    readReg(`UART_ADDR_STATUS, st);
    while (st[bitIdx] !== level && polls < limit) begin
      readReg(`UART_ADDR_STATUS, st);
      polls++;
    end
    ok = (st[bitIdx] === level);
    if (!ok) begin
      $display("Status bit %0d never reached %b by %0t", bitIdx, level, $time);
      otherErrors++;
    end
  endtask

  task automatic sendByte(input byteT b);
    writeReg(`UART_ADDR_DATA, {8'd0, b});
    txQ.push_back(b);
  endtask

  task automatic receiveByte();
    logic   ok;
    wbDataT word;
    byteT   exp;
    waitStatus(`UART_ST_RX_EMPTY, 1'b0, 1, ok);
    if (ok) begin
      readReg(`UART_ADDR_DATA, word);
      if (rxQ.size() == 0) begin
        $display("A byte was read at %0t that never appeared on txd", $time);
        otherErrors++;
      end else begin
        exp = rxQ.pop_front();
        checkWord("datO", {8'd0, exp}, word);
      end
    end
  endtask

  // Line decoder samples each bit at mid bit with the programmed period
  initial begin : lineDecoder
    byteT frame;
    byteT exp;
    int   i;
    wait (arstn === 1'b1);
    forever begin
      @(negedge lineTx);
      repeat (bitClocks / 2) @(posedge clk);
      if (lineTx !== 1'b0) begin
        $display("Start bit on txd did not last to mid bit at %0t", $time);
        otherErrors++;
      end else begin
        for (i = 0; i < 8; i++) begin
          repeat (bitClocks) @(posedge clk);
          frame[i] = lineTx;                      // LSB first
        end
        repeat (bitClocks) @(posedge clk);
        if (lineTx !== 1'b1) begin
          $display("Bad stop bit on txd at %0t", $time);
          otherErrors++;
        end else if (txQ.size() == 0) begin
          $display("Frame on txd at %0t with no byte pending", $time);
          otherErrors++;
        end else begin
          exp = txQ.pop_front();
          checkWord("txd frame", {8'd0, exp}, {8'd0, frame});
          rxQ.push_back(frame);                   // Loopback delivers it next
        end
      end
    end
  end

  // Run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == CYCLE_LIMIT) begin
      $display("Run stopped at the limit of %0d cycles", CYCLE_LIMIT);
      $display("Errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
      $display("test failed");
      $finish;
    end
  end

  initial begin : mainSeq
    wbDataT rdWord;
    logic   ok;
    byteT   b;
    int     i;
    seed        = 32'h5344_13bc;
    valueErrors = 0;
    otherErrors = 0;
    bitClocks   = `UART_BAUD_RESET;
    cyc   = 1'b0;
    stb   = 1'b0;
    we    = 1'b0;
    adr   = '0;
    datI  = '0;
    arstn = 1'b0;
    repeat (10) @(posedge clk);
    arstn <= 1'b1;
    @(posedge clk);

    // Reset state
    readReg(`UART_ADDR_STATUS, rdWord);
    checkWord("status", refStatus(0, 0), rdWord);
    checkWord("txd", 16'd1, {15'd0, lineTx});
    readReg(`UART_ADDR_BAUD, rdWord);
    checkWord("baud", `UART_BAUD_RESET, rdWord);

    // Baud register and empty data read
    writeReg(`UART_ADDR_BAUD, wbDataT'(TEST_BIT_CLOCKS));
    bitClocks = TEST_BIT_CLOCKS;
    readReg(`UART_ADDR_BAUD, rdWord);
    checkWord("baud", wbDataT'(TEST_BIT_CLOCKS), rdWord);
    readReg(`UART_ADDR_DATA, rdWord);
    checkWord("datO", 16'd0, rdWord);
    readReg(`UART_ADDR_STATUS, rdWord);
    checkWord("status", refStatus(txQ.size(), rxQ.size()), rdWord);

    // One byte out and back
    b = byteT'($random(seed));
    sendByte(b);
    receiveByte();

    // Burst fills the RX FIFO
    for (i = 0; i < BURST_A; i++) begin
      b = byteT'($random(seed));
      sendByte(b);
    end
    waitStatus(`UART_ST_RX_FULL, 1'b1, BURST_A, ok);
    if (txQ.size() != 0) begin
      $display("%0d burst bytes never appeared on txd", txQ.size());
      otherErrors++;
    end
    readReg(`UART_ADDR_STATUS, rdWord);
    checkWord("status", refStatus(txQ.size(), rxQ.size()), rdWord);
    for (i = 0; i < BURST_A; i++)
      receiveByte();
    readReg(`UART_ADDR_STATUS, rdWord);
    checkWord("status", refStatus(txQ.size(), rxQ.size()), rdWord);

    // Pointer wrap with one byte at a time
    for (i = 0; i < BURST_B; i++) begin
      b = byteT'($random(seed));
      sendByte(b);
      receiveByte();
      readReg(`UART_ADDR_STATUS, rdWord);
      checkWord("status", refStatus(txQ.size(), rxQ.size()), rdWord);
    end

    if (txQ.size() != 0 || rxQ.size() != 0) begin
      $display("Bytes missing at the end, %0d not sent, %0d not read", txQ.size(), rxQ.size());
      otherErrors++;
    end
    $display("Errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

// File: flist.f
+incdir+logic
logic/uartPkg.sv
logic/uartCore.sv
logic/byteFifo.sv
logic/uartRegs.sv
logic/uartTop.sv
test/uartTop_chk.sv
test/tb_uartTop.sv

// File: Makefile
# Verilator simulation of the UART testbench

VERILATOR ?= verilator
TOP       ?= tb_uartTop
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
FAIL_MSG  ?= test failed

SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
